// File: rtl/ioapic_defs.svh
`ifndef IOAPIC_DEFS_SVH
`define IOAPIC_DEFS_SVH

// ====================
// Sizing
// ====================

// Number of interrupt input lines
`define IOAPIC_NUM_IRQS 8

// Width of an input index
`define IOAPIC_IDX_W 3

// ====================
// APB register map
// ====================

// Byte address width of the register window
`define IOAPIC_ADDR_W 8

// ID register, APIC ID in bits 27:24
`define IOAPIC_ID_OFFSET 8'h00

// First redirection entry, one word per input after it
`define IOAPIC_REDIR_BASE 8'h10

`endif

// File: rtl/ioapic_pkg.sv
`default_nettype none

`include "ioapic_defs.svh"

package ioapic_pkg;

    // One redirection table entry as stored
    typedef struct packed {
        logic [7:0] vector;
        logic [2:0] deliv_mode;
        // Kept for readback only
        logic       dest_mode;
        // 1 = active low
        logic       polarity;
        // 1 = level, 0 = edge
        logic       trigger_level;
        // 1 = masked
        logic       mask;
        logic [7:0] destination;
    } redir_entry_t;

    // APB request bundle, driven by the bus master
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`IOAPIC_ADDR_W-1:0] paddr;
        logic [31:0]               pwdata;
    } apb_req_t;

    // APB response bundle
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Outgoing interrupt message
    typedef struct packed {
        logic [7:0] vector;
        logic [7:0] dest;
        logic [2:0] deliv_mode;
    } irq_msg_t;

    // Single-cycle event tagged with an input index
    typedef struct packed {
        logic                     valid;
        logic [`IOAPIC_IDX_W-1:0] irq;
    } deliv_evt_t;

    // Delivery FSM states
    typedef enum logic [1:0] {
        IDLE,
        DELIVER,
        WAIT_EOI
    } delivery_state_t;

endpackage

`default_nettype wire

// File: rtl/ioapic_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "ioapic_defs.svh"

module ioapic_apb_regs (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire ioapic_pkg::apb_req_t     apb_req,
    output ioapic_pkg::apb_rsp_t          apb_rsp,
    input  wire logic [`IOAPIC_NUM_IRQS-1:0] deliv_status,
    input  wire logic [`IOAPIC_NUM_IRQS-1:0] remote_irr,
    output ioapic_pkg::redir_entry_t      redir [`IOAPIC_NUM_IRQS],
    output logic [3:0]                    apic_id
);

    // Entries come out of reset masked, everything else zero
    localparam ioapic_pkg::redir_entry_t REDIR_RESET = '{mask: 1'b1, default: '0};

    logic                      access;
    logic                      wr_en;
    logic                      id_hit;
    logic                      redir_hit;
    logic [`IOAPIC_ADDR_W-1:0] redir_offs;
    logic [`IOAPIC_IDX_W-1:0]  redir_idx;

    // ====================
    // Address decode
    // ====================

    // Access phase of a transfer
    assign access = apb_req.psel && apb_req.penable;
    assign wr_en  = access && apb_req.pwrite;

    assign id_hit = (apb_req.paddr == `IOAPIC_ID_OFFSET);

    // Byte offset into the table
    assign redir_offs = apb_req.paddr - `IOAPIC_REDIR_BASE;
    assign redir_idx  = redir_offs[`IOAPIC_IDX_W+1:2];

    // Word aligned and inside the table
    assign redir_hit = (apb_req.paddr >= `IOAPIC_REDIR_BASE) &&
                       (redir_offs[1:0] == 2'b00) &&
                       (redir_offs[`IOAPIC_ADDR_W-1:2] < `IOAPIC_NUM_IRQS);

    // ====================
    // Register storage
    // ====================

    always_ff @(posedge clk) begin
        if (rst_n) begin
            apic_id <= 4'h0;
            for (int i = 0; i < `IOAPIC_NUM_IRQS; i++) begin
                redir[i] <= REDIR_RESET;
            end
        end else if (wr_en) begin
            if (id_hit) begin
                apic_id <= apb_req.pwdata[27:24];
            end else if (redir_hit) begin
                // Bits 12 and 14 are status, not stored
                redir[redir_idx].vector        <= apb_req.pwdata[7:0];
                redir[redir_idx].deliv_mode    <= apb_req.pwdata[10:8];
                redir[redir_idx].dest_mode     <= apb_req.pwdata[11];
                redir[redir_idx].polarity      <= apb_req.pwdata[13];
                redir[redir_idx].trigger_level <= apb_req.pwdata[15];
                redir[redir_idx].mask          <= apb_req.pwdata[16];
                redir[redir_idx].destination   <= apb_req.pwdata[31:24];
            end
        end
    end

    // ====================
    // Read path
    // ====================

    // Zero wait states
    assign apb_rsp.pready  = access;
    // Unmapped address
    assign apb_rsp.pslverr = access && !id_hit && !redir_hit;

    always_comb begin
        apb_rsp.prdata = 32'h0;
        if (apb_req.psel && id_hit) begin
            apb_rsp.prdata[27:24] = apic_id;
        end else if (apb_req.psel && redir_hit) begin
            // Stored fields merged with live status
            apb_rsp.prdata = {redir[redir_idx].destination,
                              7'h00,
                              redir[redir_idx].mask,
                              redir[redir_idx].trigger_level,
                              remote_irr[redir_idx],
                              redir[redir_idx].polarity,
                              deliv_status[redir_idx],
                              redir[redir_idx].dest_mode,
                              redir[redir_idx].deliv_mode,
                              redir[redir_idx].vector};
        end
    end

    // Enable only inside a selected transfer
    penable_needs_psel: assert property (
        @(posedge clk) disable iff (rst_n)
        apb_req.penable |-> apb_req.psel
    );

endmodule

`default_nettype wire

// File: rtl/ioapic_irq_input.sv
`timescale 1ns/1ps
`default_nettype none

`include "ioapic_defs.svh"

module ioapic_irq_input (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [`IOAPIC_NUM_IRQS-1:0] irq_in,
    input  wire ioapic_pkg::redir_entry_t    redir [`IOAPIC_NUM_IRQS],
    input  wire ioapic_pkg::deliv_evt_t      accept_evt,
    input  wire ioapic_pkg::deliv_evt_t      done_evt,
    input  wire logic                        eoi_valid,
    input  wire logic [7:0]                  eoi_vector,
    output logic [`IOAPIC_NUM_IRQS-1:0]      pending,
    output logic [`IOAPIC_NUM_IRQS-1:0]      remote_irr
);

    logic [`IOAPIC_NUM_IRQS-1:0] sync0;
    logic [`IOAPIC_NUM_IRQS-1:0] sync1;
    logic [`IOAPIC_NUM_IRQS-1:0] sync2;
    logic [`IOAPIC_NUM_IRQS-1:0] active;
    logic [`IOAPIC_NUM_IRQS-1:0] active_prev;
    logic [`IOAPIC_NUM_IRQS-1:0] rise;
    logic [`IOAPIC_NUM_IRQS-1:0] level_mode;
    logic [`IOAPIC_NUM_IRQS-1:0] eoi_match;

    // ====================
    // Synchronizer
    // ====================

    always_ff @(posedge clk) begin
        if (rst_n) begin
            sync0 <= '0;
            sync1 <= '0;
            sync2 <= '0;
        end else begin
            sync0 <= irq_in;
            sync1 <= sync0;
            sync2 <= sync1;
        end
    end

    // Polarity, trigger mode, EOI vector compare per line
    always_comb begin
        for (int i = 0; i < `IOAPIC_NUM_IRQS; i++) begin
            active[i]     = sync2[i] ^ redir[i].polarity;
            level_mode[i] = redir[i].trigger_level;
            eoi_match[i]  = eoi_valid && (eoi_vector == redir[i].vector);
        end
    end

    // Rising edge of the active level
    assign rise = active & ~active_prev;

    // ====================
    // Pending and Remote IRR
    // ====================

    always_ff @(posedge clk) begin
        if (rst_n) begin
            active_prev <= '0;
            pending     <= '0;
            remote_irr  <= '0;
        end else begin
            active_prev <= active;
            for (int i = 0; i < `IOAPIC_NUM_IRQS; i++) begin
                if (level_mode[i]) begin
                    // Level held off while an EOI is outstanding
                    pending[i] <= active[i] && !remote_irr[i];
                end else if (rise[i]) begin
                    // New edge wins over a same-cycle clear
                    pending[i] <= 1'b1;
                end else if (done_evt.valid && (done_evt.irq == `IOAPIC_IDX_W'(i))) begin
                    pending[i] <= 1'b0;
                end

                if (!level_mode[i]) begin
                    remote_irr[i] <= 1'b0;
                end else if (accept_evt.valid && (accept_evt.irq == `IOAPIC_IDX_W'(i))) begin
                    remote_irr[i] <= 1'b1;
                end else if (eoi_match[i]) begin
                    remote_irr[i] <= 1'b0;
                end
            end
        end
    end

    // Remote IRR only ever set under level mode
    remote_irr_level_only: assert property (
        @(posedge clk) disable iff (rst_n)
        (remote_irr & ~level_mode) == '0
    );

endmodule

`default_nettype wire

// File: rtl/ioapic_delivery.sv
`timescale 1ns/1ps
`default_nettype none

`include "ioapic_defs.svh"

module ioapic_delivery (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [`IOAPIC_NUM_IRQS-1:0] pending,
    input  wire logic [`IOAPIC_NUM_IRQS-1:0] remote_irr,
    input  wire ioapic_pkg::redir_entry_t    redir [`IOAPIC_NUM_IRQS],
    output ioapic_pkg::irq_msg_t             msg,
    output logic                             msg_valid,
    input  wire logic                        msg_ready,
    output ioapic_pkg::deliv_evt_t           accept_evt,
    output ioapic_pkg::deliv_evt_t           done_evt,
    output logic [`IOAPIC_NUM_IRQS-1:0]      deliv_status
);

    ioapic_pkg::delivery_state_t state;
    ioapic_pkg::delivery_state_t state_nxt;

    logic [`IOAPIC_NUM_IRQS-1:0] eligible;
    logic [`IOAPIC_IDX_W-1:0]    sel_idx;
    logic                        sel_valid;
    logic [`IOAPIC_IDX_W-1:0]    cur_irq;
    logic                        cur_level;

    // ====================
    // Arbiter
    // ====================

    always_comb begin
        sel_idx   = '0;
        sel_valid = 1'b0;
        // Scan down so the lowest index lands last
        for (int i = `IOAPIC_NUM_IRQS - 1; i >= 0; i--) begin
            eligible[i] = pending[i] && !redir[i].mask;
            if (eligible[i]) begin
                sel_idx   = `IOAPIC_IDX_W'(i);
                sel_valid = 1'b1;
            end
        end
    end

    // ====================
    // Delivery FSM
    // ====================

    always_comb begin
        state_nxt = state;
        case (state)
            ioapic_pkg::IDLE: begin
                if (sel_valid) begin
                    state_nxt = ioapic_pkg::DELIVER;
                end
            end
            ioapic_pkg::DELIVER: begin
                // Level waits for EOI, edge is done on take
                if (msg_ready) begin
                    state_nxt = cur_level ? ioapic_pkg::WAIT_EOI : ioapic_pkg::IDLE;
                end
            end
            ioapic_pkg::WAIT_EOI: begin
                if (!remote_irr[cur_irq]) begin
                    state_nxt = ioapic_pkg::IDLE;
                end
            end
            default: begin
                state_nxt = ioapic_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state <= ioapic_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Snapshot of the winner, taken on leaving IDLE
    always_ff @(posedge clk) begin
        if (accept_evt.valid) begin
            cur_irq        <= sel_idx;
            cur_level      <= redir[sel_idx].trigger_level;
            msg.vector     <= redir[sel_idx].vector;
            msg.dest       <= redir[sel_idx].destination;
            msg.deliv_mode <= redir[sel_idx].deliv_mode;
        end
    end

    // ====================
    // Outputs
    // ====================

    assign msg_valid = (state == ioapic_pkg::DELIVER);

    assign accept_evt.valid = (state == ioapic_pkg::IDLE) && sel_valid;
    assign accept_evt.irq   = sel_idx;

    // Take of the message
    assign done_evt.valid = msg_valid && msg_ready;
    assign done_evt.irq   = cur_irq;

    // In flight from accept until back in IDLE
    always_comb begin
        for (int i = 0; i < `IOAPIC_NUM_IRQS; i++) begin
            deliv_status[i] = (state != ioapic_pkg::IDLE) && (cur_irq == `IOAPIC_IDX_W'(i));
        end
    end

    deliv_status_onehot: assert property (
        @(posedge clk) disable iff (rst_n)
        $onehot0(deliv_status)
    );

    // Message held under back-pressure
    msg_stable: assert property (
        @(posedge clk) disable iff (rst_n)
        msg_valid && !msg_ready |=> msg_valid && $stable(msg)
    );

endmodule

`default_nettype wire

// File: rtl/ioapic_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ioapic_defs.svh"

module ioapic_top (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire ioapic_pkg::apb_req_t        apb_req,
    output ioapic_pkg::apb_rsp_t             apb_rsp,
    input  wire logic [`IOAPIC_NUM_IRQS-1:0] irq_in,
    output ioapic_pkg::irq_msg_t             msg,
    output logic                             msg_valid,
    input  wire logic                        msg_ready,
    input  wire logic                        eoi_valid,
    input  wire logic [7:0]                  eoi_vector
);

    ioapic_pkg::redir_entry_t    redir [`IOAPIC_NUM_IRQS];
    ioapic_pkg::deliv_evt_t      accept_evt;
    ioapic_pkg::deliv_evt_t      done_evt;
    logic [`IOAPIC_NUM_IRQS-1:0] pending;
    logic [`IOAPIC_NUM_IRQS-1:0] remote_irr;
    logic [`IOAPIC_NUM_IRQS-1:0] deliv_status;

    // Register window, APIC ID only read back
    ioapic_apb_regs ioapic_apb_regs_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .deliv_status (deliv_status),
        .remote_irr   (remote_irr),
        .redir        (redir),
        .apic_id      ()
    );

    // Line conditioning and pending state
    ioapic_irq_input ioapic_irq_input_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .irq_in     (irq_in),
        .redir      (redir),
        .accept_evt (accept_evt),
        .done_evt   (done_evt),
        .eoi_valid  (eoi_valid),
        .eoi_vector (eoi_vector),
        .pending    (pending),
        .remote_irr (remote_irr)
    );

    // Arbitration and message handshake
    ioapic_delivery ioapic_delivery_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .pending      (pending),
        .remote_irr   (remote_irr),
        .redir        (redir),
        .msg          (msg),
        .msg_valid    (msg_valid),
        .msg_ready    (msg_ready),
        .accept_evt   (accept_evt),
        .done_evt     (done_evt),
        .deliv_status (deliv_status)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset level is high, dropped just after an edge
    initial begin
        rst_n = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b0;
    end

endmodule

`default_nettype wire

// File: test/ioapic_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ioapic_defs.svh"

module ioapic_top_tb;

    localparam int DRIVE_DLY     = 2;
    localparam int MSG_TIMEOUT   = 50;
    localparam int APB_TIMEOUT   = 16;
    localparam int RESET_TIMEOUT = 20;
    localparam int QUIET_CYCLES  = 30;

    logic                        clk;
    logic                        rst_n;
    ioapic_pkg::apb_req_t        apb_req;
    ioapic_pkg::apb_rsp_t        apb_rsp;
    logic [`IOAPIC_NUM_IRQS-1:0] irq_in;
    ioapic_pkg::irq_msg_t        msg;
    logic                        msg_valid;
    logic                        msg_ready;
    logic                        eoi_valid;
    logic [7:0]                  eoi_vector;
    int                          failures;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(5)) tb_clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ioapic_top ioapic_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .irq_in     (irq_in),
        .msg        (msg),
        .msg_valid  (msg_valid),
        .msg_ready  (msg_ready),
        .eoi_valid  (eoi_valid),
        .eoi_vector (eoi_vector)
    );

    // ====================
    // Checks
    // ====================

    task automatic fail_now(input string what);
        failures++;
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "stopping on first error");
    endtask

    task automatic compare_msg(input string test, input ioapic_pkg::irq_msg_t exp,
                               input ioapic_pkg::irq_msg_t act);
        string exp_str;
        string act_str;
        if (act !== exp) begin
            exp_str = $sformatf("vec=%02h dest=%02h mode=%0d",
                                exp.vector, exp.dest, exp.deliv_mode);
            act_str = $sformatf("vec=%02h dest=%02h mode=%0d",
                                act.vector, act.dest, act.deliv_mode);
            fail_now($sformatf("FAIL %s: expected %s, actual %s", test, exp_str, act_str));
        end
    endtask

    task automatic compare_word(input string test, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            fail_now($sformatf("FAIL %s: expected %08h, actual %08h", test, exp, act));
        end
    endtask

    task automatic compare_bit(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("FAIL %s: expected %b, actual %b", test, exp, act));
        end
    endtask

    // ====================
    // Register map helpers
    // ====================

    function automatic logic [`IOAPIC_ADDR_W-1:0] redir_addr(input int n);
        return `IOAPIC_REDIR_BASE + `IOAPIC_ADDR_W'(4 * n);
    endfunction

    // Entry word as laid out in the register map, status bits zero
    function automatic logic [31:0] entry_word(input logic [7:0] vector, input logic [2:0] mode,
                                               input logic dest_mode, input logic polarity,
                                               input logic level, input logic mask,
                                               input logic [7:0] dest);
        logic [31:0] w;
        w        = '0;
        w[7:0]   = vector;
        w[10:8]  = mode;
        w[11]    = dest_mode;
        w[13]    = polarity;
        w[15]    = level;
        w[16]    = mask;
        w[31:24] = dest;
        return w;
    endfunction

    function automatic ioapic_pkg::irq_msg_t make_msg(input logic [7:0] vector,
                                                      input logic [7:0] dest,
                                                      input logic [2:0] mode);
        ioapic_pkg::irq_msg_t m;
        m.vector     = vector;
        m.dest       = dest;
        m.deliv_mode = mode;
        return m;
    endfunction

    // ====================
    // Bus and line drivers
    // ====================

    // One APB transfer, starts and ends at the drive point
    task automatic apb_access(input logic write, input logic [`IOAPIC_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        int waited;
        waited          = 0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DLY;
        apb_req.penable = 1'b1;
        // Sample mid-cycle
        @(negedge clk);
        while (!apb_rsp.pready) begin
            waited++;
            if (waited >= APB_TIMEOUT) begin
                fail_now("APB transfer never completed, pready stayed low");
            end
            @(negedge clk);
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        #DRIVE_DLY;
        apb_req = '0;
    endtask

    task automatic apb_write(input string test, input logic [`IOAPIC_ADDR_W-1:0] addr,
                             input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        compare_bit(test, 1'b0, err);
    endtask

    task automatic apb_read(input string test, input logic [`IOAPIC_ADDR_W-1:0] addr,
                            output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'h0, data, err);
        compare_bit(test, 1'b0, err);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic send_eoi(input logic [7:0] vector);
        eoi_valid  = 1'b1;
        eoi_vector = vector;
        @(posedge clk);
        #DRIVE_DLY;
        eoi_valid  = 1'b0;
    endtask

    // Ends at the negedge where msg_valid is seen
    task automatic wait_valid(input string test);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!msg_valid) begin
            waited++;
            if (waited >= MSG_TIMEOUT) begin
                fail_now($sformatf("%s: no message arrived within %0d cycles",
                                   test, MSG_TIMEOUT));
            end
            @(negedge clk);
        end
    endtask

    // Message checked, then taken on the next edge with ready high
    task automatic expect_msg(input string test, input ioapic_pkg::irq_msg_t exp);
        wait_valid(test);
        compare_msg(test, exp, msg);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic expect_quiet(input string test, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_bit(test, 1'b0, msg_valid);
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // ====================
    // Directed tests
    // ====================

    task automatic test_registers();
        logic [31:0] rd;
        logic [31:0] word;
        logic        err;
        compare_bit("registers", 1'b0, msg_valid);
        compare_bit("registers", 1'b0, apb_rsp.pslverr);
        // Reset state, all entries masked
        for (int i = 0; i < `IOAPIC_NUM_IRQS; i++) begin
            apb_read("registers", redir_addr(i), rd);
            compare_word("registers", entry_word(8'h00, 3'b000, 0, 0, 0, 1, 8'h00), rd);
        end
        apb_read("registers", `IOAPIC_ID_OFFSET, rd);
        compare_word("registers", 32'h0, rd);
        apb_write("registers", `IOAPIC_ID_OFFSET, 32'h0A00_0000);
        apb_read("registers", `IOAPIC_ID_OFFSET, rd);
        compare_word("registers", 32'h0A00_0000, rd);
        // Every stored field set, still masked
        word = entry_word(8'h5C, 3'b101, 1, 1, 1, 1, 8'hA5);
        apb_write("registers", redir_addr(7), word);
        apb_read("registers", redir_addr(7), rd);
        compare_word("registers", word, rd);
        // Hole in the map
        apb_access(1'b1, 8'h08, 32'hFFFF_FFFF, rd, err);
        compare_bit("registers", 1'b1, err);
        apb_access(1'b0, 8'h08, 32'h0, rd, err);
        compare_bit("registers", 1'b1, err);
        apb_read("registers", `IOAPIC_ID_OFFSET, rd);
        compare_word("registers", 32'h0A00_0000, rd);
    endtask

    task automatic test_edge();
        apb_write("edge", redir_addr(1), entry_word(8'h31, 3'b001, 0, 0, 0, 0, 8'h0F));
        irq_in[1] = 1'b1;
        expect_msg("edge", make_msg(8'h31, 8'h0F, 3'b001));
        // Line stays high, no second edge
        expect_quiet("edge", QUIET_CYCLES);
        irq_in[1] = 1'b0;
        wait_cycles(5);
    endtask

    task automatic test_masking();
        apb_write("masking", redir_addr(4), entry_word(8'h44, 3'b010, 0, 0, 0, 1, 8'h22));
        irq_in[4] = 1'b1;
        expect_quiet("masking", QUIET_CYCLES);
        // Latched edge goes out once unmasked
        apb_write("masking", redir_addr(4), entry_word(8'h44, 3'b010, 0, 0, 0, 0, 8'h22));
        expect_msg("masking", make_msg(8'h44, 8'h22, 3'b010));
        irq_in[4] = 1'b0;
        expect_quiet("masking", 10);
    endtask

    task automatic test_priority();
        apb_write("priority", redir_addr(2), entry_word(8'h52, 3'b000, 0, 0, 0, 0, 8'h02));
        apb_write("priority", redir_addr(5), entry_word(8'h55, 3'b000, 0, 0, 0, 0, 8'h05));
        irq_in[2] = 1'b1;
        irq_in[5] = 1'b1;
        // Lower index first
        expect_msg("priority", make_msg(8'h52, 8'h02, 3'b000));
        expect_msg("priority", make_msg(8'h55, 8'h05, 3'b000));
        expect_quiet("priority", QUIET_CYCLES);
        irq_in[2] = 1'b0;
        irq_in[5] = 1'b0;
        wait_cycles(5);
    endtask

    task automatic test_level();
        logic [31:0] rd;
        // Active low, so idle line is high
        irq_in[6] = 1'b1;
        wait_cycles(5);
        apb_write("level", redir_addr(6), entry_word(8'h66, 3'b100, 0, 1, 1, 1, 8'h06));
        wait_cycles(5);
        apb_write("level", redir_addr(6), entry_word(8'h66, 3'b100, 0, 1, 1, 0, 8'h06));
        expect_quiet("level", 10);
        irq_in[6] = 1'b0;
        expect_msg("level", make_msg(8'h66, 8'h06, 3'b100));
        // Remote IRR now set
        apb_read("level", redir_addr(6), rd);
        compare_bit("level", 1'b1, rd[14]);
        expect_quiet("level", QUIET_CYCLES);
        // Line still active, so EOI redelivers
        send_eoi(8'h66);
        expect_msg("level", make_msg(8'h66, 8'h06, 3'b100));
        irq_in[6] = 1'b1;
        wait_cycles(6);
        send_eoi(8'h66);
        expect_quiet("level", QUIET_CYCLES);
        apb_read("level", redir_addr(6), rd);
        compare_bit("level", 1'b0, rd[14]);
    endtask

    task automatic test_backpressure();
        ioapic_pkg::irq_msg_t exp;
        int                   takes;
        exp   = make_msg(8'h73, 8'h33, 3'b011);
        takes = 0;
        apb_write("backpressure", redir_addr(3), entry_word(8'h73, 3'b011, 0, 0, 0, 0, 8'h33));
        msg_ready = 1'b0;
        irq_in[3] = 1'b1;
        wait_valid("backpressure");
        // Held steady while stalled
        for (int i = 0; i < 10; i++) begin
            compare_bit("backpressure", 1'b1, msg_valid);
            compare_msg("backpressure", exp, msg);
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
        msg_ready = 1'b1;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (msg_valid && msg_ready) begin
                takes++;
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        compare_word("backpressure", 32'd1, 32'(takes));
        irq_in[3] = 1'b0;
        wait_cycles(5);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int waited;
        failures   = 0;
        waited     = 0;
        apb_req    = '0;
        irq_in     = '0;
        msg_ready  = 1'b1;
        eoi_valid  = 1'b0;
        eoi_vector = 8'h00;

        // Out of reset before any stimulus
        @(posedge clk);
        while (rst_n) begin
            waited++;
            if (waited >= RESET_TIMEOUT) begin
                fail_now("reset was never released");
            end
            @(posedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;

        test_registers();
        test_edge();
        test_masking();
        test_priority();
        test_level();
        test_backpressure();

        if (failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ioapic_top.f
+incdir+rtl
rtl/ioapic_pkg.sv
rtl/ioapic_apb_regs.sv
rtl/ioapic_irq_input.sv
rtl/ioapic_delivery.sv
rtl/ioapic_top.sv
test/tb_clock_gen.sv
test/ioapic_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f ioapic_top.f --top-module ioapic_top_tb -o ioapic_sim

sim_out=$(./obj_dir/ioapic_sim 2>&1)
echo "$sim_out"

if grep -q "=== PASS ===" <<< "$sim_out"; then
    exit 0
fi
exit 1
